/* fft_sample_pkg.sv */
`default_nettype none

package fft_sample_pkg;

  // ********************
  // Sample and product formats
  // ********************

  localparam int data_w = 16; // Q1.15 real or imaginary part.
  localparam int prod_w = 2 * data_w + 2; // Two products summed, plus rounding headroom.

  typedef logic signed [data_w-1:0] sample_t;
  typedef logic signed [prod_w-1:0] prod_t;

  // Round half up, then arithmetic shift.
  function automatic prod_t round_shift(input prod_t x, input int unsigned sh);
    prod_t half;
    half = (sh == 0) ? prod_t'(0) : (prod_t'(1) <<< (sh - 1));
    return (x + half) >>> sh;
  endfunction

  function automatic sample_t saturate(input prod_t x);
    prod_t hi;
    prod_t lo;
    hi = prod_t'(2 ** (data_w - 1) - 1);
    lo = -hi - prod_t'(1);
    if (x > hi) begin
      return sample_t'(hi);
    end else if (x < lo) begin
      return sample_t'(lo);
    end
    return sample_t'(x);
  endfunction

endpackage

`default_nettype wire

/* fft_twiddle_pkg.sv */
`default_nettype none

package fft_twiddle_pkg;

  // ********************
  // Coefficient format
  // ********************

  localparam int coef_w = 16;
  localparam int coef_frac = 15; // Q1.15, so 1.0 is 2**15.
  localparam int coef_max = 2 ** (coef_w - 1) - 1; // 1.0 clips to this.

  typedef logic signed [coef_w-1:0] coef_t;

  localparam real pi = 3.14159265358979323846;

  // ********************
  // Octant opcode
  // ********************

  localparam int oct_w = 3;

  // Octant of the twiddle angle, selects swap and negation of the base pair.
  typedef enum logic [oct_w-1:0] {
    oct_0 = 3'd0, // 0 to 45 degrees.
    oct_1 = 3'd1,
    oct_2 = 3'd2,
    oct_3 = 3'd3,
    oct_4 = 3'd4, // 180 to 225 degrees.
    oct_5 = 3'd5,
    oct_6 = 3'd6,
    oct_7 = 3'd7
  } octant_e;

endpackage

`default_nettype wire

/* octant_decoder.sv */
`default_nettype none

module octant_decoder #(
  parameter int log2_n = 5
) (
  input  wire [log2_n-1:0]      k,
  output fft_twiddle_pkg::octant_e octant,
  output logic [log2_n-3:0]     base_idx
);

  localparam int r_w = log2_n - 3; // Index bits inside one octant.
  localparam int m_w = log2_n - 2; // Base index reaches N/8 itself.
  localparam logic [m_w-1:0] eighth = m_w'(1) << r_w; // N/8.

  logic [r_w-1:0] r;
  logic           odd_oct;

  // ********************
  // Index split
  // ********************

  assign octant = fft_twiddle_pkg::octant_e'(k[log2_n-1 -: fft_twiddle_pkg::oct_w]);
  assign r = k[r_w-1:0];
  assign odd_oct = k[r_w]; // Lowest octant bit.

  // Odd octants run backwards through the base table.
  always_comb begin
    if (odd_oct) begin
      base_idx = eighth - {1'b0, r};
    end else begin
      base_idx = {1'b0, r};
    end
  end

endmodule

`default_nettype wire

/* twiddle_rom.sv */
`default_nettype none

module twiddle_rom #(
  parameter int log2_n = 5
) (
  input  wire                    clk,
  input  wire [log2_n-3:0]       base_idx,
  output fft_twiddle_pkg::coef_t cos_val,
  output fft_twiddle_pkg::coef_t sin_val
);

  localparam int n_pts = 2 ** log2_n;
  localparam int depth = n_pts / 8 + 1; // First octant, both ends included.

  // Scaled, rounded to nearest and clipped into Q1.15.
  function automatic fft_twiddle_pkg::coef_t base_coef(input int m, input bit want_sin);
    real ang;
    real scaled;
    int  q;
    ang = 2.0 * fft_twiddle_pkg::pi * real'(m) / real'(n_pts);
    scaled = (want_sin ? $sin(ang) : $cos(ang)) * real'(2 ** fft_twiddle_pkg::coef_frac);
    q = $rtoi(scaled + 0.5); // Values are never negative here.
    if (q > fft_twiddle_pkg::coef_max) begin
      q = fft_twiddle_pkg::coef_max;
    end
    return fft_twiddle_pkg::coef_t'(q);
  endfunction

  fft_twiddle_pkg::coef_t cos_tab [depth];
  fft_twiddle_pkg::coef_t sin_tab [depth];

  // ********************
  // Table contents
  // ********************

  for (genvar m = 0; m < depth; m++) begin : g_tab
    assign cos_tab[m] = base_coef(m, 1'b0);
    assign sin_tab[m] = base_coef(m, 1'b1);
  end

  // The decoder never drives an index above N/8.
  always_ff @(posedge clk) begin
    cos_val <= cos_tab[base_idx];
    sin_val <= sin_tab[base_idx];
  end

endmodule

`default_nettype wire

/* complex_mult.sv */
`default_nettype none

module complex_mult (
  input  wire                       clk,
  input  wire                       arst_n,
  input  wire                       in_valid,
  input  wire fft_sample_pkg::sample_t b_re,
  input  wire fft_sample_pkg::sample_t b_im,
  input  wire fft_twiddle_pkg::coef_t  c,
  input  wire fft_twiddle_pkg::coef_t  s,
  output logic                      out_valid,
  output fft_sample_pkg::sample_t   p_re,
  output fft_sample_pkg::sample_t   p_im
);

  fft_sample_pkg::prod_t br_c;
  fft_sample_pkg::prod_t bi_s;
  fft_sample_pkg::prod_t bi_c;
  fft_sample_pkg::prod_t br_s;
  fft_sample_pkg::prod_t sum_re;
  fft_sample_pkg::prod_t sum_im;

  // ********************
  // Partial products
  // ********************

  assign br_c = fft_sample_pkg::prod_t'(b_re) * fft_sample_pkg::prod_t'(c);
  assign bi_s = fft_sample_pkg::prod_t'(b_im) * fft_sample_pkg::prod_t'(s);
  assign bi_c = fft_sample_pkg::prod_t'(b_im) * fft_sample_pkg::prod_t'(c);
  assign br_s = fft_sample_pkg::prod_t'(b_re) * fft_sample_pkg::prod_t'(s);

  // Multiply by c - js.
  assign sum_re = br_c + bi_s;
  assign sum_im = bi_c - br_s;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    p_re <= fft_sample_pkg::saturate(
              fft_sample_pkg::round_shift(sum_re, fft_twiddle_pkg::coef_frac));
    p_im <= fft_sample_pkg::saturate(
              fft_sample_pkg::round_shift(sum_im, fft_twiddle_pkg::coef_frac));
  end

endmodule

`default_nettype wire

/* twiddle_rotator.sv */
`default_nettype none

module twiddle_rotator #(
  parameter int log2_n = 5
) (
  input  wire                       clk,
  input  wire                       arst_n,
  input  wire                       in_valid,
  input  wire [log2_n-1:0]          k,
  input  wire fft_sample_pkg::sample_t b_re,
  input  wire fft_sample_pkg::sample_t b_im,
  output logic                      out_valid,
  output fft_sample_pkg::sample_t   wb_re,
  output fft_sample_pkg::sample_t   wb_im
);

  fft_twiddle_pkg::octant_e octant;
  logic [log2_n-3:0]        base_idx;
  fft_twiddle_pkg::coef_t   cos_val;
  fft_twiddle_pkg::coef_t   sin_val;

  fft_twiddle_pkg::octant_e oct_q;
  fft_sample_pkg::sample_t  b_re_q;
  fft_sample_pkg::sample_t  b_im_q;
  logic                     vld_q;

  fft_twiddle_pkg::coef_t   c_nxt;
  fft_twiddle_pkg::coef_t   s_nxt;
  fft_twiddle_pkg::coef_t   c_q;
  fft_twiddle_pkg::coef_t   s_q;
  fft_sample_pkg::sample_t  b_re_qq;
  fft_sample_pkg::sample_t  b_im_qq;
  logic                     vld_qq;

  // ********************
  // Stage 1, table read
  // ********************

  octant_decoder #(.log2_n(log2_n)) u_octant_decoder (
    .k       (k),
    .octant  (octant),
    .base_idx(base_idx)
  );

  twiddle_rom #(.log2_n(log2_n)) u_twiddle_rom (
    .clk     (clk),
    .base_idx(base_idx),
    .cos_val (cos_val),
    .sin_val (sin_val)
  );

  always_ff @(posedge clk) begin
    oct_q <= octant; // Opcode rides next to the ROM read.
    b_re_q <= b_re;
    b_im_q <= b_im;
  end

  // ********************
  // Stage 2, octant swap
  // ********************

  // Base values are never negative, so negation cannot overflow.
  always_comb begin
    case (oct_q)
      fft_twiddle_pkg::oct_1: begin
        c_nxt = sin_val;
        s_nxt = cos_val;
      end
      fft_twiddle_pkg::oct_2: begin
        c_nxt = -sin_val;
        s_nxt = cos_val;
      end
      fft_twiddle_pkg::oct_3: begin
        c_nxt = -cos_val;
        s_nxt = sin_val;
      end
      fft_twiddle_pkg::oct_4: begin
        c_nxt = -cos_val;
        s_nxt = -sin_val;
      end
      fft_twiddle_pkg::oct_5: begin
        c_nxt = -sin_val;
        s_nxt = -cos_val;
      end
      fft_twiddle_pkg::oct_6: begin
        c_nxt = sin_val;
        s_nxt = -cos_val;
      end
      fft_twiddle_pkg::oct_7: begin
        c_nxt = cos_val;
        s_nxt = -sin_val;
      end
      default: begin // Octant 0.
        c_nxt = cos_val;
        s_nxt = sin_val;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    c_q <= c_nxt;
    s_q <= s_nxt;
    b_re_qq <= b_re_q;
    b_im_qq <= b_im_q;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      vld_q <= 1'b0;
      vld_qq <= 1'b0;
    end else begin
      vld_q <= in_valid;
      vld_qq <= vld_q;
    end
  end

  // ********************
  // Stage 3, multiply
  // ********************

  complex_mult u_complex_mult (
    .clk      (clk),
    .arst_n   (arst_n),
    .in_valid (vld_qq),
    .b_re     (b_re_qq),
    .b_im     (b_im_qq),
    .c        (c_q),
    .s        (s_q),
    .out_valid(out_valid),
    .p_re     (wb_re),
    .p_im     (wb_im)
  );

endmodule

`default_nettype wire

/* radix2_butterfly.sv */
`default_nettype none

module radix2_butterfly (
  input  wire                       clk,
  input  wire                       arst_n,
  input  wire                       in_valid,
  input  wire fft_sample_pkg::sample_t a_re,
  input  wire fft_sample_pkg::sample_t a_im,
  input  wire fft_sample_pkg::sample_t wb_re,
  input  wire fft_sample_pkg::sample_t wb_im,
  output logic                      out_valid,
  output fft_sample_pkg::sample_t   y0_re,
  output fft_sample_pkg::sample_t   y0_im,
  output fft_sample_pkg::sample_t   y1_re,
  output fft_sample_pkg::sample_t   y1_im
);

  localparam int sum_w = fft_sample_pkg::data_w + 1; // One guard bit.

  logic signed [sum_w-1:0] sum_re;
  logic signed [sum_w-1:0] sum_im;
  logic signed [sum_w-1:0] dif_re;
  logic signed [sum_w-1:0] dif_im;

  assign sum_re = sum_w'(a_re) + sum_w'(wb_re);
  assign sum_im = sum_w'(a_im) + sum_w'(wb_im);
  assign dif_re = sum_w'(a_re) - sum_w'(wb_re);
  assign dif_im = sum_w'(a_im) - sum_w'(wb_im);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
    end
  end

  // Halving brings the guard bit back into range.
  always_ff @(posedge clk) begin
    y0_re <= fft_sample_pkg::sample_t'(sum_re >>> 1);
    y0_im <= fft_sample_pkg::sample_t'(sum_im >>> 1);
    y1_re <= fft_sample_pkg::sample_t'(dif_re >>> 1);
    y1_im <= fft_sample_pkg::sample_t'(dif_im >>> 1);
  end

endmodule

`default_nettype wire

/* fft_butterfly_top.sv */
`default_nettype none

module fft_butterfly_top #(
  parameter int log2_n = 5
) (
  input  wire                       clk,
  input  wire                       arst_n,
  input  wire                       in_valid,
  input  wire [log2_n-1:0]          k,
  input  wire fft_sample_pkg::sample_t a_re,
  input  wire fft_sample_pkg::sample_t a_im,
  input  wire fft_sample_pkg::sample_t b_re,
  input  wire fft_sample_pkg::sample_t b_im,
  output logic                      out_valid,
  output fft_sample_pkg::sample_t   y0_re,
  output fft_sample_pkg::sample_t   y0_im,
  output fft_sample_pkg::sample_t   y1_re,
  output fft_sample_pkg::sample_t   y1_im
);

  localparam int a_dly = 3; // Matches the rotator latency.

  fft_sample_pkg::sample_t a_re_d [a_dly];
  fft_sample_pkg::sample_t a_im_d [a_dly];

  logic                    wb_valid;
  fft_sample_pkg::sample_t wb_re;
  fft_sample_pkg::sample_t wb_im;

  logic                    bf_valid;
  fft_sample_pkg::sample_t bf0_re;
  fft_sample_pkg::sample_t bf0_im;
  fft_sample_pkg::sample_t bf1_re;
  fft_sample_pkg::sample_t bf1_im;

  // ********************
  // Sample a alignment
  // ********************

  always_ff @(posedge clk) begin
    a_re_d[0] <= a_re;
    a_im_d[0] <= a_im;
    for (int i = 1; i < a_dly; i++) begin
      a_re_d[i] <= a_re_d[i-1];
      a_im_d[i] <= a_im_d[i-1];
    end
  end

  twiddle_rotator #(.log2_n(log2_n)) u_twiddle_rotator (
    .clk      (clk),
    .arst_n   (arst_n),
    .in_valid (in_valid),
    .k        (k),
    .b_re     (b_re),
    .b_im     (b_im),
    .out_valid(wb_valid),
    .wb_re    (wb_re),
    .wb_im    (wb_im)
  );

  radix2_butterfly u_radix2_butterfly (
    .clk      (clk),
    .arst_n   (arst_n),
    .in_valid (wb_valid),
    .a_re     (a_re_d[a_dly-1]),
    .a_im     (a_im_d[a_dly-1]),
    .wb_re    (wb_re),
    .wb_im    (wb_im),
    .out_valid(bf_valid),
    .y0_re    (bf0_re),
    .y0_im    (bf0_im),
    .y1_re    (bf1_re),
    .y1_im    (bf1_im)
  );

  // ********************
  // Output stage
  // ********************

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= bf_valid; // Fifth cycle after the strobe.
    end
  end

  always_ff @(posedge clk) begin
    y0_re <= bf0_re;
    y0_im <= bf0_im;
    y1_re <= bf1_re;
    y1_im <= bf1_im;
  end

endmodule

`default_nettype wire

/* fft_butterfly_props.sv */
`default_nettype none

module fft_butterfly_props (
  input wire                          clk,
  input wire                          arst_n,
  input wire                          in_valid,
  input wire                          out_valid,
  input wire fft_sample_pkg::sample_t y0_re,
  input wire fft_sample_pkg::sample_t y0_im,
  input wire fft_sample_pkg::sample_t y1_re,
  input wire fft_sample_pkg::sample_t y1_im
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int latency = 5;

  // Valid bits clear asynchronously.
  reset_quiet: assert property (@(posedge clk) !arst_n |-> !out_valid)
    else $error("out_valid high while reset is asserted");

  // One output strobe per input strobe, no back-pressure.
  latency_exact: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid == $past(in_valid, latency))
    else $error("out_valid does not follow in_valid by %0d cycles", latency);

  outputs_known: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid |-> !$isunknown({y0_re, y0_im, y1_re, y1_im}))
    else $error("unknown bits on butterfly outputs with out_valid high");

endmodule

bind fft_butterfly_top fft_butterfly_props u_fft_butterfly_props (
  .clk      (clk),
  .arst_n   (arst_n),
  .in_valid (in_valid),
  .out_valid(out_valid),
  .y0_re    (y0_re),
  .y0_im    (y0_im),
  .y1_re    (y1_re),
  .y1_im    (y1_im)
);

`default_nettype wire

/* tb_fft_butterfly.sv */
`default_nettype none

module tb_fft_butterfly;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int log2_n = 5;
  localparam int n_pts = 1 << log2_n;
  localparam int eighth = n_pts / 8;
  localparam int latency = 5;
  localparam int drive_delay = 10;
  localparam int wait_limit = 40;
  localparam real pi_val = 3.14159265358979323846;

  typedef struct packed {
    int                      cyc;
    fft_sample_pkg::sample_t y0_re;
    fft_sample_pkg::sample_t y0_im;
    fft_sample_pkg::sample_t y1_re;
    fft_sample_pkg::sample_t y1_im;
  } result_t;

  logic                    clk;
  logic                    arst_n;
  logic                    in_valid;
  logic [log2_n-1:0]       k;
  fft_sample_pkg::sample_t a_re;
  fft_sample_pkg::sample_t a_im;
  fft_sample_pkg::sample_t b_re;
  fft_sample_pkg::sample_t b_im;
  logic                    out_valid;
  fft_sample_pkg::sample_t y0_re;
  fft_sample_pkg::sample_t y0_im;
  fft_sample_pkg::sample_t y1_re;
  fft_sample_pkg::sample_t y1_im;

  result_t     exp_q[$];
  int          cycle_cnt = 0;
  logic [31:0] lfsr_state = 32'h921254e4;

  fft_butterfly_top #(.log2_n(log2_n)) u_fft_butterfly_top (
    .clk      (clk),
    .arst_n   (arst_n),
    .in_valid (in_valid),
    .k        (k),
    .a_re     (a_re),
    .a_im     (a_im),
    .b_re     (b_re),
    .b_im     (b_im),
    .out_valid(out_valid),
    .y0_re    (y0_re),
    .y0_im    (y0_im),
    .y1_re    (y1_re),
    .y1_im    (y1_im)
  );

  always #50 clk = ~clk; // 100 ns period.

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  // ********************
  // Failure reporting and compares
  // ********************

  task automatic stop_on_failure(input string line);
    $display("%s", line);
    $display("Some tests failed");
    $fatal(1, "Simulation stopped after a failure.");
  endtask

  task automatic report_mismatch(input string msg);
    stop_on_failure($sformatf("[ERROR] %0d ns: %s", $time, msg));
  endtask

  task automatic check_valid(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      report_mismatch($sformatf("%s is %b, expected %b", what, got, exp));
    end
  endtask

  task automatic check_sample(input string what, input fft_sample_pkg::sample_t got,
                              input fft_sample_pkg::sample_t exp);
    if (got !== exp) begin
      report_mismatch($sformatf("%s is %0d, expected %0d", what, got, exp));
    end
  endtask

  // ********************
  // Reference model
  // ********************

  function automatic int ref_coef(input int m, input bit want_sin);
    real ang;
    real v;
    int  q;
    ang = 2.0 * pi_val * real'(m) / real'(n_pts);
    v = want_sin ? $sin(ang) : $cos(ang);
    q = int'($floor(v * 32768.0 + 0.5));
    return (q > 32767) ? 32767 : q;
  endfunction

  function automatic int clip_q15(input longint x);
    if (x > 64'sd32767) begin
      return 32767;
    end else if (x < -64'sd32768) begin
      return -32768;
    end
    return int'(x);
  endfunction

  function automatic result_t predict(input int kk, input int ar, input int ai,
                                      input int br, input int bi, input int cyc);
    int      oct;
    int      r;
    int      m;
    int      cb;
    int      sb;
    int      c;
    int      s;
    int      wr;
    int      wi;
    result_t res;
    oct = kk / eighth;
    r = kk % eighth;
    m = (oct % 2 == 1) ? eighth - r : r;
    cb = ref_coef(m, 1'b0);
    sb = ref_coef(m, 1'b1);
    c = (((oct + 1) / 2) % 2 == 1) ? sb : cb; // Octants 1, 2, 5 and 6 swap.
    s = (((oct + 1) / 2) % 2 == 1) ? cb : sb;
    if (oct >= 2 && oct <= 5) begin
      c = -c;
    end
    if (oct >= 4) begin
      s = -s;
    end
    wr = clip_q15((longint'(br) * c + longint'(bi) * s + 64'sd16384) >>> 15);
    wi = clip_q15((longint'(bi) * c - longint'(br) * s + 64'sd16384) >>> 15);
    res.cyc = cyc;
    res.y0_re = fft_sample_pkg::sample_t'((ar + wr) >>> 1);
    res.y0_im = fft_sample_pkg::sample_t'((ai + wi) >>> 1);
    res.y1_re = fft_sample_pkg::sample_t'((ar - wr) >>> 1);
    res.y1_im = fft_sample_pkg::sample_t'((ai - wi) >>> 1);
    return res;
  endfunction

  // Taps 32, 22, 2, 1.
  function automatic logic lfsr_step();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_step()};
    end
    return v;
  endfunction

  // ********************
  // Driving
  // ********************

  task automatic step();
    @(posedge clk);
    #drive_delay;
  endtask

  task automatic idle();
    in_valid = 1'b0;
  endtask

  task automatic send_butterfly(input logic [log2_n-1:0] kk,
                                input fft_sample_pkg::sample_t ar,
                                input fft_sample_pkg::sample_t ai,
                                input fft_sample_pkg::sample_t br,
                                input fft_sample_pkg::sample_t bi);
    k = kk;
    a_re = ar;
    a_im = ai;
    b_re = br;
    b_im = bi;
    in_valid = 1'b1;
    exp_q.push_back(predict(int'(kk), int'(ar), int'(ai), int'(br), int'(bi), cycle_cnt));
  endtask

  task automatic send_random();
    logic [31:0] rk;
    rk = rand_bits(log2_n);
    send_butterfly(rk[log2_n-1:0],
                   fft_sample_pkg::sample_t'(rand_bits(16)),
                   fft_sample_pkg::sample_t'(rand_bits(16)),
                   fft_sample_pkg::sample_t'(rand_bits(16)),
                   fft_sample_pkg::sample_t'(rand_bits(16)));
  endtask

  task automatic wait_drain(input string phase);
    int cnt;
    cnt = 0;
    while (exp_q.size() != 0 && cnt < wait_limit * 4) begin
      step();
      cnt++;
    end
    if (exp_q.size() != 0) begin
      stop_on_failure($sformatf("Timed out waiting for results in the %s test.", phase));
    end
  endtask

  // Results are due exactly at the strobe cycle plus the latency.
  always @(negedge clk) begin
    if (arst_n) begin
      if (exp_q.size() == 0) begin
        check_valid("out_valid with nothing in flight", out_valid, 1'b0);
      end else if (cycle_cnt == exp_q[0].cyc + latency) begin
        check_valid("out_valid", out_valid, 1'b1);
        check_sample("y0_re", y0_re, exp_q[0].y0_re);
        check_sample("y0_im", y0_im, exp_q[0].y0_im);
        check_sample("y1_re", y1_re, exp_q[0].y1_re);
        check_sample("y1_im", y1_im, exp_q[0].y1_im);
        void'(exp_q.pop_front());
      end else begin
        check_valid("out_valid before the next result is due", out_valid, 1'b0);
      end
    end
  end

  // ********************
  // Tests
  // ********************

  task automatic test_reset();
    for (int i = 0; i < 5; i++) begin
      step();
      check_valid("out_valid in reset", out_valid, 1'b0);
    end
    arst_n = 1'b1;
    for (int i = 0; i < 8; i++) begin
      step(); // Monitor checks the idle outputs.
    end
  endtask

  task automatic test_latency();
    int lat;
    send_butterfly(log2_n'(3), 16'sd1000, -16'sd2000, 16'sd12000, 16'sd7000);
    step();
    idle();
    lat = 1;
    while (!out_valid && lat < wait_limit) begin
      step();
      lat++;
    end
    if (!out_valid) begin
      stop_on_failure("out_valid never rose after a single strobe.");
    end
    if (lat != latency) begin
      report_mismatch($sformatf("latency is %0d cycles, expected %0d", lat, latency));
    end
    wait_drain("latency");
    for (int i = 0; i < 8; i++) begin
      step();
    end
  endtask

  task automatic test_octants();
    for (int i = 0; i < n_pts; i++) begin
      send_butterfly(log2_n'(i), 16'sd0, 16'sd0, 16'sd16384, 16'sd0); // b = 0.5.
      step();
    end
    idle();
    wait_drain("octant");
  endtask

  task automatic test_back_to_back();
    for (int i = 0; i < 64; i++) begin
      send_random();
      step();
    end
    idle();
    wait_drain("back-to-back");
  endtask

  task automatic test_saturation();
    fft_sample_pkg::sample_t vr;
    fft_sample_pkg::sample_t vi;
    for (int q = 0; q < 4; q++) begin
      for (int i = 0; i < 4; i++) begin
        vr = (i % 2 == 1) ? 16'sh8000 : 16'sh7fff;
        vi = (i / 2 == 1) ? 16'sh8000 : 16'sh7fff;
        send_butterfly(log2_n'((2 * q + 1) * eighth), vi, vr, vr, vi);
        step();
      end
    end
    idle();
    wait_drain("saturation");
  endtask

  task automatic test_gapped();
    int gap;
    for (int i = 0; i < 24; i++) begin
      send_random();
      step();
      idle();
      gap = int'(rand_bits(2));
      for (int j = 0; j < gap; j++) begin
        step();
      end
    end
    wait_drain("gapped");
  endtask

  initial begin
    clk = 1'b0;
    arst_n = 1'b0;
    in_valid = 1'b0;
    k = '0;
    a_re = '0;
    a_im = '0;
    b_re = '0;
    b_im = '0;
    test_reset();
    test_latency();
    test_octants();
    test_back_to_back();
    test_saturation();
    test_gapped();
    for (int i = 0; i < 8; i++) begin
      step();
    end
    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
fft_sample_pkg.sv
fft_twiddle_pkg.sv
octant_decoder.sv
twiddle_rom.sv
complex_mult.sv
twiddle_rotator.sv
radix2_butterfly.sv
fft_butterfly_top.sv
fft_butterfly_props.sv
tb_fft_butterfly.sv

/* Makefile */
# Verilator build of the FFT butterfly testbench.

VERILATOR ?= verilator
TOP       ?= tb_fft_butterfly
BUILD_DIR ?= build
FILELIST  ?= compile.f
VFLAGS    ?= --binary --timing --assert

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes.
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Exit status of the binary is the test result.
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(BUILD_DIR)
